//--- rapid_pkg.sv
package rapid_pkg;

    //////////////////////////////////////////////////////////////////////
    // Core-wide constants
    //////////////////////////////////////////////////////////////////////

    // Data and address width of the core
    localparam int XLEN = 32;

    // Byte step between two sequential instructions
    localparam int WORD_WIDTH = 4;

    // Program counter value out of reset
    localparam logic [XLEN-1:0] RESET_VECTOR = 32'h0000_0000;

    // Fetch stops for good once this word has been handed off
    localparam logic [XLEN-1:0] HALT_INSTR = 32'h0010_0073;

    //////////////////////////////////////////////////////////////////////
    // Fetch FSM
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        FETCH,  // request is out and the cache answer is pending
        WAIT,   // instruction held until the next stage takes it
        NEXT,   // program counter settled and the request goes out next
        HALT    // halt word delivered so nothing more is fetched
    } if_state_t;

endpackage

//--- icache_pkg.sv
package icache_pkg;

    //////////////////////////////////////////////////////////////////////
    // Cache geometry
    //////////////////////////////////////////////////////////////////////

    // Direct mapped with one word per line
    localparam int CACHE_LINES = 16;
    localparam int INDEX_BITS  = 4;

    // Whatever is left above the index and the byte offset
    localparam int TAG_BITS = rapid_pkg::XLEN - INDEX_BITS - 2;

    //////////////////////////////////////////////////////////////////////
    // Instruction memory
    //////////////////////////////////////////////////////////////////////

    // Depth in words and the width of a word index
    localparam int MEM_WORDS     = 256;
    localparam int MEM_ADDR_BITS = 8;

    // Cycles from an accepted read to the response pulse
    localparam int MEM_LATENCY = 4;

    // Width of the latency down-counter
    localparam int LAT_CNT_BITS = $clog2(MEM_LATENCY + 1);

    // Cache controller states
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL_REQ,
        REFILL_WAIT
    } cache_state_t;

endpackage

//--- instruction_memory.sv
`timescale 1ns/1ps

module instruction_memory
    import rapid_pkg::*, icache_pkg::*;
(
    input  logic                     i_clk,
    input  logic                     i_reset,

    // Program load port, used while reset is held
    input  logic                     i_load_en,
    input  logic [MEM_ADDR_BITS-1:0] i_load_addr,
    input  logic [XLEN-1:0]          i_load_data,

    // Read request channel
    input  logic                     i_req_valid,
    output logic                     o_req_ready,
    input  logic [MEM_ADDR_BITS-1:0] i_req_addr,

    // Read response, one cycle pulse
    output logic                     o_rsp_valid,
    output logic [XLEN-1:0]          o_rsp_data
);

    // Word storage
    logic [XLEN-1:0]          mem [0:MEM_WORDS-1];

    // Address of the read in flight
    logic [MEM_ADDR_BITS-1:0] addr_q;

    // Cycles left until the response
    logic [LAT_CNT_BITS-1:0]  count;
    logic                     accept;

    //////////////////////////////////////////////////////////////////////
    // Request handshake
    //////////////////////////////////////////////////////////////////////

    // Only one read at a time so ready drops while the counter runs
    assign o_req_ready = (count == '0);
    assign accept      = i_req_valid & o_req_ready;

    // Testbench writes one word per cycle
    always_ff @(posedge i_clk) begin
        if (i_load_en) begin
            mem[i_load_addr] <= i_load_data;
        end
    end

    // Latch the word index when the read is taken
    always_ff @(posedge i_clk) begin
        if (accept) begin
            addr_q <= i_req_addr;
        end
    end

    // Latency counter
    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            count <= '0;
        end else if (accept) begin
            count <= LAT_CNT_BITS'(MEM_LATENCY);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Response
    //////////////////////////////////////////////////////////////////////

    // Last count before idle is the response cycle
    assign o_rsp_valid = (count == LAT_CNT_BITS'(1));
    assign o_rsp_data  = mem[addr_q];

endmodule

//--- i_cache.sv
`timescale 1ns/1ps

module i_cache
    import rapid_pkg::*, icache_pkg::*;
(
    input  logic                     i_clk,
    input  logic                     i_reset,

    // Fetch side, one cycle strobe in and one cycle done out
    input  logic                     i_req,
    input  logic [XLEN-1:0]          i_address,
    output logic                     o_done,
    output logic [XLEN-1:0]          o_data,

    // Refill request toward memory
    output logic                     o_mem_req_valid,
    input  logic                     i_mem_req_ready,
    output logic [MEM_ADDR_BITS-1:0] o_mem_req_addr,

    // Refill response, always accepted
    input  logic                     i_mem_rsp_valid,
    input  logic [XLEN-1:0]          i_mem_rsp_data
);

    cache_state_t              state;
    cache_state_t              next_state;

    // Word address of the current request, byte offset dropped
    logic [XLEN-1:2]           addr_q;

    // Line storage
    logic [XLEN-1:0]           data_arr  [0:CACHE_LINES-1];
    logic [TAG_BITS-1:0]       tag_arr   [0:CACHE_LINES-1];
    logic [CACHE_LINES-1:0]    valid_arr;

    // Address fields
    logic [INDEX_BITS-1:0]     index;
    logic [TAG_BITS-1:0]       tag;
    logic                      hit;
    logic                      fill;

    assign index = addr_q[INDEX_BITS+1:2];
    assign tag   = addr_q[XLEN-1:INDEX_BITS+2];

    // Stored tag must match and the line must be live
    assign hit  = valid_arr[index] & (tag_arr[index] == tag);

    // Refill word arrives
    assign fill = (state == REFILL_WAIT) & i_mem_rsp_valid;

    //////////////////////////////////////////////////////////////////////
    // Controller
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (i_req) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                // Hit finishes here, miss goes to memory
                if (hit) begin
                    next_state = IDLE;
                end else begin
                    next_state = REFILL_REQ;
                end
            end
            REFILL_REQ: begin
                if (i_mem_req_ready) begin
                    next_state = REFILL_WAIT;
                end
            end
            REFILL_WAIT: begin
                // Back to LOOKUP, which now hits on the fresh line
                if (i_mem_rsp_valid) begin
                    next_state = LOOKUP;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Request address is held for the whole access
    always_ff @(posedge i_clk) begin
        if ((state == IDLE) && i_req) begin
            addr_q <= i_address[XLEN-1:2];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Line update
    //////////////////////////////////////////////////////////////////////

    // Payload arrays
    always_ff @(posedge i_clk) begin
        if (fill) begin
            data_arr[index] <= i_mem_rsp_data;
            tag_arr[index]  <= tag;
        end
    end

    // Valid bits, all lines empty after reset
    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            valid_arr <= '0;
        end else if (fill) begin
            valid_arr[index] <= 1'b1;
        end
    end

    // Outputs
    assign o_done          = (state == LOOKUP) & hit;
    assign o_data          = data_arr[index];
    assign o_mem_req_valid = (state == REFILL_REQ);
    assign o_mem_req_addr  = addr_q[MEM_ADDR_BITS+1:2];  // memory is word addressed

endmodule

//--- instruction_fetch.sv
`timescale 1ns/1ps

module instruction_fetch
    import rapid_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_reset,

    // Next stage handshake
    input  logic            i_ready,
    input  logic            i_redirect,
    input  logic [XLEN-1:0] i_redirect_pc,
    output logic            o_valid,
    output logic [XLEN-1:0] o_pc,
    output logic [XLEN-1:0] o_instruction,
    output logic            o_halted,

    // Cache request channel
    output logic            o_cache_req,
    output logic [XLEN-1:0] o_cache_addr,
    input  logic            i_cache_done,
    input  logic [XLEN-1:0] i_cache_data
);

    if_state_t       state;

    // Program counter of the instruction being fetched or held
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] next_pc;
    logic            transfer;

    // Handoff happens when both sides agree
    assign transfer = o_valid & i_ready;

    // Redirect wins over the sequential step
    always_comb begin
        if (i_redirect) begin
            // Keep the target even
            next_pc = {i_redirect_pc[XLEN-1:1], 1'b0};
        end else begin
            next_pc = pc + XLEN'(WORD_WIDTH);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Fetch FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            // Start in NEXT so the first request goes out right away
            state       <= NEXT;
            pc          <= RESET_VECTOR;
            o_valid     <= 1'b0;
            o_halted    <= 1'b0;
            o_cache_req <= 1'b0;
        end else begin
            // Request strobe lasts one cycle
            o_cache_req <= 1'b0;
            case (state)
                NEXT: begin
                    state       <= FETCH;
                    o_cache_req <= 1'b1;
                end
                FETCH: begin
                    if (i_cache_done) begin
                        state   <= WAIT;
                        o_valid <= 1'b1;
                    end
                end
                WAIT: begin
                    // Outputs stay put until the next stage takes them
                    if (transfer) begin
                        o_valid <= 1'b0;
                        if (o_instruction == HALT_INSTR) begin
                            state    <= HALT;
                            o_halted <= 1'b1;
                        end else begin
                            state <= NEXT;
                            pc    <= next_pc;
                        end
                    end
                end
                HALT: begin
                    // Only reset leaves here
                    state <= HALT;
                end
                default: state <= NEXT;
            endcase
        end
    end

    // Instruction register loads on cache done
    always_ff @(posedge i_clk) begin
        if ((state == FETCH) && i_cache_done) begin
            o_instruction <= i_cache_data;
        end
    end

    assign o_pc         = pc;
    assign o_cache_addr = pc;

endmodule

//--- fetch_unit_top.sv
`timescale 1ns/1ps

module fetch_unit_top
    import rapid_pkg::*, icache_pkg::*;
(
    input  logic                     i_clk,
    input  logic                     i_reset,

    // Pipeline side
    input  logic                     i_ready,
    input  logic                     i_redirect,
    input  logic [XLEN-1:0]          i_redirect_pc,

    // Program load while in reset
    input  logic                     i_load_en,
    input  logic [MEM_ADDR_BITS-1:0] i_load_addr,
    input  logic [XLEN-1:0]          i_load_data,

    output logic                     o_valid,
    output logic [XLEN-1:0]          o_pc,
    output logic [XLEN-1:0]          o_instruction,
    output logic                     o_halted
);

    // Fetch to cache
    logic                     cache_req;
    logic [XLEN-1:0]          cache_addr;
    logic                     cache_done;
    logic [XLEN-1:0]          cache_data;

    // Cache to memory
    logic                     mem_req_valid;
    logic                     mem_req_ready;
    logic [MEM_ADDR_BITS-1:0] mem_req_addr;
    logic                     mem_rsp_valid;
    logic [XLEN-1:0]          mem_rsp_data;

    instruction_fetch u_fetch (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_ready       (i_ready),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .o_valid       (o_valid),
        .o_pc          (o_pc),
        .o_instruction (o_instruction),
        .o_halted      (o_halted),
        .o_cache_req   (cache_req),
        .o_cache_addr  (cache_addr),
        .i_cache_done  (cache_done),
        .i_cache_data  (cache_data)
    );

    i_cache u_cache (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_req           (cache_req),
        .i_address       (cache_addr),
        .o_done          (cache_done),
        .o_data          (cache_data),
        .o_mem_req_valid (mem_req_valid),
        .i_mem_req_ready (mem_req_ready),
        .o_mem_req_addr  (mem_req_addr),
        .i_mem_rsp_valid (mem_rsp_valid),
        .i_mem_rsp_data  (mem_rsp_data)
    );

    instruction_memory u_mem (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_load_en   (i_load_en),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .i_req_valid (mem_req_valid),
        .o_req_ready (mem_req_ready),
        .i_req_addr  (mem_req_addr),
        .o_rsp_valid (mem_rsp_valid),
        .o_rsp_data  (mem_rsp_data)
    );

endmodule

//--- tb_fetch_unit.sv
`timescale 1ns/1ps

module tb_fetch_unit
    import rapid_pkg::*, icache_pkg::*;
();

    //////////////////////////////////////////////////////////////////////
    // Run limits and stimulus constants
    //////////////////////////////////////////////////////////////////////

    localparam int RESET_CYCLES = 10;
    localparam int HALT_INDEX   = 5;
    localparam int HALT_QUIET   = 50;

    // Two program loads plus about 40 transfers at worst-case miss cost
    localparam int CYCLE_LIMIT = 2 * (MEM_WORDS + RESET_CYCLES) + 40 * (MEM_LATENCY + 10);

    logic                     i_clk;
    logic                     i_reset;
    logic                     i_ready;
    logic                     i_redirect;
    logic [XLEN-1:0]          i_redirect_pc;
    logic                     i_load_en;
    logic [MEM_ADDR_BITS-1:0] i_load_addr;
    logic [XLEN-1:0]          i_load_data;
    logic                     o_valid;
    logic [XLEN-1:0]          o_pc;
    logic [XLEN-1:0]          o_instruction;
    logic                     o_halted;

    // Reference copy of the program and the expected next fetch address
    logic [XLEN-1:0]          golden_mem [0:MEM_WORDS-1];
    logic [XLEN-1:0]          exp_pc;
    logic [31:0]              lcg_state = 32'h15812e69;
    int                       cycle_count = 0;
    int                       error_count = 0;

    fetch_unit_top DUT (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_ready       (i_ready),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .i_load_en     (i_load_en),
        .i_load_addr   (i_load_addr),
        .i_load_data   (i_load_data),
        .o_valid       (o_valid),
        .o_pc          (o_pc),
        .o_instruction (o_instruction),
        .o_halted      (o_halted)
    );

    // 20 ns clock
    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Error reporting and timeout
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string line);
        error_count++;
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic fail_value(input string msg);
        abort_run($sformatf("[FAIL] t=%0t %s", $time, msg));
    endtask

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            abort_run($sformatf("Timeout: the run did not finish within %0d clock cycles",
                                CYCLE_LIMIT));
        end
    end

    // Linear congruential generator
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Handshake helpers
    //////////////////////////////////////////////////////////////////////

    // Program words never equal the halt word
    task automatic fill_golden();
        logic [XLEN-1:0] word;
        for (int i = 0; i < MEM_WORDS; i++) begin
            word = next_random();
            while (word == HALT_INSTR) begin
                word = next_random();
            end
            golden_mem[i] = word;
        end
    endtask

    // Reset held over the load and then for the usual reset cycles
    task automatic reset_and_load(input logic full_load);
        @(negedge i_clk);
        i_reset = 1'b1;
        i_ready = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (full_load || i == HALT_INDEX) begin
                i_load_en   = 1'b1;
                i_load_addr = MEM_ADDR_BITS'(i);
                i_load_data = golden_mem[i];
                @(negedge i_clk);
            end
        end
        i_load_en = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge i_clk);
            assert (!o_valid && !o_halted)
                else fail_value("o_valid or o_halted high during reset");
        end
        i_reset = 1'b0;
        exp_pc  = RESET_VECTOR;
    endtask

    // Cycles from the last transfer edge until o_valid is seen
    task automatic await_valid(output int cycles);
        cycles = 0;
        while (!o_valid) begin
            @(posedge i_clk);
            cycles++;
            @(negedge i_clk);
        end
    endtask

    // Word on the outputs against the reference model
    task automatic check_delivery();
        logic [XLEN-1:0] exp_instr;
        exp_instr = golden_mem[exp_pc[MEM_ADDR_BITS+1:2]];
        assert (o_valid)
            else fail_value("o_valid low where an instruction was expected");
        assert (o_pc == exp_pc)
            else fail_value($sformatf("o_pc %h, expected %h", o_pc, exp_pc));
        assert (o_instruction == exp_instr)
            else fail_value($sformatf("o_instruction %h at pc %h, expected %h",
                                      o_instruction, o_pc, exp_instr));
    endtask

    // Optional stall, then one transfer with or without redirect
    task automatic hand_off(input logic redirect, input logic [XLEN-1:0] target,
                            input int hold);
        logic [XLEN-1:0] held_pc;
        logic [XLEN-1:0] held_instr;
        check_delivery();
        held_pc    = o_pc;
        held_instr = o_instruction;
        for (int i = 0; i < hold; i++) begin
            @(posedge i_clk);
            @(negedge i_clk);
            assert (o_valid && o_pc == held_pc && o_instruction == held_instr)
                else fail_value($sformatf("output moved under stall, pc %h instr %h",
                                          o_pc, o_instruction));
        end
        i_ready       = 1'b1;
        i_redirect    = redirect;
        i_redirect_pc = target;
        @(posedge i_clk);
        @(negedge i_clk);
        i_ready       = 1'b0;
        i_redirect    = 1'b0;
        i_redirect_pc = '0;
        // Next address per the redirect rule
        if (redirect) begin
            exp_pc = {target[XLEN-1:1], 1'b0};
        end else begin
            exp_pc = exp_pc + XLEN'(WORD_WIDTH);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic fetch_in_order();
        int lat;
        for (int k = 0; k < 8; k++) begin
            await_valid(lat);
            assert (o_pc == RESET_VECTOR + XLEN'(4 * k))
                else fail_value($sformatf("transfer %0d delivered pc %h", k, o_pc));
            hand_off(1'b0, '0, 0);
        end
    endtask

    // Random stall lengths of 1 to 16 cycles
    task automatic hold_under_stall();
        int lat;
        int hold;
        for (int r = 0; r < 4; r++) begin
            await_valid(lat);
            hold = 1 + int'(next_random() % 16);
            hand_off(1'b0, '0, hold);
        end
    endtask

    // Odd targets inside the loaded range
    task automatic redirect_to_odd_target();
        int              lat;
        logic [XLEN-1:0] target;
        for (int r = 0; r < 3; r++) begin
            await_valid(lat);
            target = (next_random() & 32'h0000_03FF) | 32'h1;
            hand_off(1'b1, target, 0);
            await_valid(lat);
            assert (o_pc == {target[XLEN-1:1], 1'b0})
                else fail_value($sformatf("redirect to %h delivered pc %h", target, o_pc));
            check_delivery();
        end
    endtask

    // Fresh tag misses and the same address again is resident
    task automatic measure_hit_latency();
        int              lat;
        logic [XLEN-1:0] fresh;
        await_valid(lat);
        fresh = 32'h8000_0000 | (next_random() & 32'h0000_03FC);
        hand_off(1'b1, fresh, 0);
        await_valid(lat);
        // Miss adds LOOKUP, REFILL_REQ, the memory wait and the fill cycle
        assert (lat == MEM_LATENCY + 5)
            else fail_value($sformatf("first fetch of %h took %0d cycles, expected %0d",
                                      fresh, lat, MEM_LATENCY + 5));
        hand_off(1'b1, fresh, 0);
        await_valid(lat);
        assert (lat == 3)
            else fail_value($sformatf("hit on %h took %0d cycles, expected 3", fresh, lat));
        check_delivery();
    endtask

    // Second run with the halt word planted in memory
    task automatic stop_at_halt();
        int lat;
        golden_mem[HALT_INDEX] = HALT_INSTR;
        reset_and_load(1'b0);
        for (int k = 0; k <= HALT_INDEX; k++) begin
            await_valid(lat);
            assert (!o_halted)
                else fail_value("o_halted high before the halt word was taken");
            hand_off(1'b0, '0, 0);
        end
        repeat (HALT_QUIET) begin
            assert (o_halted && !o_valid)
                else fail_value($sformatf("after halt o_halted %b o_valid %b",
                                          o_halted, o_valid));
            @(posedge i_clk);
            @(negedge i_clk);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        i_reset       = 1'b1;
        i_ready       = 1'b0;
        i_redirect    = 1'b0;
        i_redirect_pc = '0;
        i_load_en     = 1'b0;
        i_load_addr   = '0;
        i_load_data   = '0;
        exp_pc        = RESET_VECTOR;
        fill_golden();
        reset_and_load(1'b1);
        fetch_in_order();
        hold_under_stall();
        redirect_to_odd_target();
        measure_hit_latency();
        stop_at_halt();
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
rapid_pkg.sv
icache_pkg.sv
instruction_memory.sv
i_cache.sv
instruction_fetch.sv
fetch_unit_top.sv
tb_fetch_unit.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the fetch unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f list.f \
    --top-module tb_fetch_unit \
    -o sim_fetch_unit

# Exit status of the simulator is not trusted, the output decides
sim_out=$(./obj_dir/sim_fetch_unit 2>&1 || true)
echo "$sim_out"

if echo "$sim_out" | grep -qxF ">>> PASS"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
